// ==== common/net_stream_pkg.sv ====
// ----------------------------------------------------------
// net stream package
// stream widths, beat record and transmit source count
// shared by every data-path block
// ----------------------------------------------------------

package net_stream_pkg;

    // ------------------------------------------------------
    // widths
    // ------------------------------------------------------
    localparam int NET_DATA_BITS = 64;
    localparam int NET_KEEP_BITS = NET_DATA_BITS / 8;   // one keep bit per byte

    localparam int N_TX_SOURCES = 4;                    // transmit peers by default

    typedef logic [NET_DATA_BITS-1:0] net_data_t;
    typedef logic [NET_KEEP_BITS-1:0] net_keep_t;
    typedef logic [1:0]               tx_src_t;         // source index

    // ------------------------------------------------------
    // one stream beat, valid and ready travel beside it
    // ------------------------------------------------------
    typedef struct packed {
        net_data_t data;
        net_keep_t keep;
        logic      last;    // end of packet
    } net_beat_t;

endpackage

// ==== common/net_cfg_pkg.sv ====
// ----------------------------------------------------------
// net configuration package
// address, counter and statistics types and the two
// status records the stack reports
// ----------------------------------------------------------

package net_cfg_pkg;

    import net_stream_pkg::*;

    // ------------------------------------------------------
    // addresses
    // ------------------------------------------------------
    typedef logic [31:0] ip_addr_t;     // last octet in top byte
    typedef logic [47:0] mac_addr_t;
    typedef logic [3:0]  board_num_t;

    // ------------------------------------------------------
    // counters
    // ------------------------------------------------------
    typedef logic [31:0] stat_cnt_t;
    typedef logic [7:0]  down_cnt_t;

    typedef struct packed {
        mac_addr_t mac;
        ip_addr_t  ip;
        ip_addr_t  subnet_mask;
        ip_addr_t  gateway;
    } addr_cfg_t;

    typedef struct packed {
        stat_cnt_t                    rx_word_cnt;
        stat_cnt_t                    rx_pkt_cnt;
        stat_cnt_t                    tx_word_cnt;
        stat_cnt_t                    tx_pkt_cnt;
        stat_cnt_t [N_TX_SOURCES-1:0] src_pkt_cnt;  // per transmit peer
        down_cnt_t                    down_cnt;
        logic                         stream_down;  // sticky
    } net_stats_t;

endpackage

// ==== verilog/net_reg_slice.sv ====
// ----------------------------------------------------------
// stream register slice
// two-entry skid buffer, registered ready, one beat per
// cycle, beats leave in order
// ----------------------------------------------------------

`timescale 1ns/1ps

module net_reg_slice import net_stream_pkg::*; (
    input  logic      nclk,
    input  logic      nresetn_r,
    input  logic      s_valid,
    output logic      s_ready,
    input  net_beat_t s_beat,
    output logic      m_valid,
    input  logic      m_ready,
    output net_beat_t m_beat
);

    logic      main_valid;
    logic      spare_valid;
    net_beat_t main_beat;
    net_beat_t spare_beat;
    logic      main_load;       // main register takes input
    logic      spare_load;      // input parks in spare

    assign main_load  = s_ready && (!main_valid || m_ready);
    assign spare_load = s_ready && s_valid && main_valid && !m_ready;

    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_load) begin
            main_valid <= s_valid;
        end else if (spare_load) begin
            spare_valid <= 1'b1;                    // full, ready drops
        end else if (!s_ready && m_ready) begin
            spare_valid <= 1'b0;                    // spare moves to main
        end
    end

    always_ff @(posedge nclk) begin
        if (main_load) begin
            main_beat <= s_beat;
        end else if (!s_ready && m_ready) begin
            main_beat <= spare_beat;
        end
        if (spare_load) begin
            spare_beat <= s_beat;
        end
    end

    assign s_ready = !spare_valid;
    assign m_valid = main_valid;
    assign m_beat  = main_beat;

endmodule

// ==== verilog/net_addr_regs.sv ====
// ----------------------------------------------------------
// local address registers
// IP and board number set by strobes, MAC, gateway and
// subnet mask derived one cycle later
// ----------------------------------------------------------

`timescale 1ns/1ps

module net_addr_regs import net_cfg_pkg::*; #(
    parameter mac_addr_t MAC_ADDRESS    = 48'hE59D_0335_0A00,
    parameter ip_addr_t  DEFAULT_IP     = 32'hD1D4_010B,
    parameter ip_addr_t  IP_SUBNET_MASK = 32'h00FF_FFFF
) (
    input  logic       nclk,
    input  logic       nresetn_r,
    input  logic       set_ip_valid,
    input  ip_addr_t   set_ip_data,
    input  logic       set_board_valid,
    input  board_num_t set_board_data,
    output addr_cfg_t  addr_cfg
);

    ip_addr_t   local_ip;
    board_num_t board_num;
    mac_addr_t  mac_addr;
    ip_addr_t   subnet_mask;
    ip_addr_t   gateway;

    // strobed registers
    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            local_ip  <= DEFAULT_IP;
            board_num <= '0;
        end else begin
            if (set_ip_valid) begin
                local_ip <= {set_ip_data[7:0], set_ip_data[15:8],
                             set_ip_data[23:16], set_ip_data[31:24]};   // byte swap
            end
            if (set_board_valid) begin
                board_num <= set_board_data;
            end
        end
    end

    // derived fields
    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            mac_addr    <= '0;
            subnet_mask <= '0;
            gateway     <= '0;
        end else begin
            mac_addr    <= {MAC_ADDRESS[47:44], MAC_ADDRESS[43:40] + board_num,
                            MAC_ADDRESS[39:0]};                // nibble wraps mod 16
            subnet_mask <= IP_SUBNET_MASK;
            gateway     <= {8'h01, local_ip[23:0]};            // host .1 of the subnet
        end
    end

    assign addr_cfg = '{mac: mac_addr, ip: local_ip, subnet_mask: subnet_mask,
                        gateway: gateway};

endmodule

// ==== tx_merge/tx_arbiter.sv ====
// ----------------------------------------------------------
// transmit merge
// packet-locked round-robin arbiter, one source owns the
// output from grant until its last beat transfers
// ----------------------------------------------------------

`timescale 1ns/1ps

module tx_arbiter import net_stream_pkg::*; #(
    parameter int N_SOURCES = N_TX_SOURCES
) (
    input  logic                      nclk,
    input  logic                      nresetn_r,
    input  logic      [N_SOURCES-1:0] s_valid,
    output logic      [N_SOURCES-1:0] s_ready,
    input  net_beat_t [N_SOURCES-1:0] s_beat,
    output logic                      m_valid,
    input  logic                      m_ready,
    output net_beat_t                 m_beat
);

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_t;

    arb_state_t state;
    tx_src_t    grant;          // current or last owner
    tx_src_t    pick;           // next owner in round-robin order
    logic       pick_hit;

    // ------------------------------------------------------
    // round-robin search, starting after the last owner
    // ------------------------------------------------------
    always_comb begin
        int unsigned idx;
        pick_hit = 1'b0;
        pick     = grant;
        for (int i = 1; i <= N_SOURCES; i++) begin
            idx = (int'(grant) + i) % N_SOURCES;
            if (!pick_hit && s_valid[idx]) begin
                pick_hit = 1'b1;
                pick     = tx_src_t'(idx);
            end
        end
    end

    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            state <= ARB_IDLE;
            grant <= tx_src_t'(N_SOURCES - 1);      // source 0 wins first
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_hit) begin
                        state <= ARB_LOCKED;
                        grant <= pick;
                    end
                end
                ARB_LOCKED: begin
                    if (m_valid && m_ready && m_beat.last) begin
                        state <= ARB_IDLE;          // packet done
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------
    // locked path is combinational
    // ------------------------------------------------------
    always_comb begin
        s_ready = '0;
        if (state == ARB_LOCKED) begin
            s_ready[grant] = m_ready;
        end
    end

    assign m_valid = (state == ARB_LOCKED) && s_valid[grant];
    assign m_beat  = s_beat[grant];

endmodule

// ==== net_stats/net_stats.sv ====
// ----------------------------------------------------------
// traffic statistics
// word and packet counters on both network sides, per
// source packet counters, stream-down detector, delayed out
// ----------------------------------------------------------

`timescale 1ns/1ps

module net_stats import net_stream_pkg::*, net_cfg_pkg::*; #(
    parameter int N_SOURCES       = N_TX_SOURCES,
    parameter int NET_STATS_DELAY = 6,
    parameter int DOWN_LIMIT      = 2
) (
    input  logic                 nclk,
    input  logic                 nresetn_r,
    input  logic                 rx_valid,
    input  logic                 rx_ready,
    input  logic                 rx_last,
    input  logic                 tx_valid,
    input  logic                 tx_ready,
    input  logic                 tx_last,
    input  logic [N_SOURCES-1:0] src_valid,
    input  logic [N_SOURCES-1:0] src_ready,
    input  logic [N_SOURCES-1:0] src_last,
    output net_stats_t           stats
);

    logic                 rx_word;      // sampled handshakes
    logic                 rx_pkt;
    logic                 tx_word;
    logic                 tx_pkt;
    logic                 rx_stall;
    logic                 rx_free;
    logic [N_SOURCES-1:0] src_pkt;

    net_stats_t                        cnt;
    net_stats_t [NET_STATS_DELAY-1:0]  pipe;

    // ------------------------------------------------------
    // input sampling
    // ------------------------------------------------------
    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            rx_word  <= 1'b0;
            rx_pkt   <= 1'b0;
            tx_word  <= 1'b0;
            tx_pkt   <= 1'b0;
            rx_stall <= 1'b0;
            rx_free  <= 1'b0;
            src_pkt  <= '0;
        end else begin
            rx_word  <= rx_valid && rx_ready;
            rx_pkt   <= rx_valid && rx_ready && rx_last;
            tx_word  <= tx_valid && tx_ready;
            tx_pkt   <= tx_valid && tx_ready && tx_last;
            rx_stall <= rx_valid && !rx_ready;
            rx_free  <= rx_ready;
            src_pkt  <= src_valid & src_ready & src_last;
        end
    end

    // ------------------------------------------------------
    // counters
    // ------------------------------------------------------
    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            cnt <= '0;
        end else begin
            if (rx_word) cnt.rx_word_cnt <= cnt.rx_word_cnt + 1'b1;
            if (rx_pkt)  cnt.rx_pkt_cnt  <= cnt.rx_pkt_cnt + 1'b1;
            if (tx_word) cnt.tx_word_cnt <= cnt.tx_word_cnt + 1'b1;
            if (tx_pkt)  cnt.tx_pkt_cnt  <= cnt.tx_pkt_cnt + 1'b1;
            for (int i = 0; i < N_SOURCES; i++) begin
                if (src_pkt[i]) begin
                    cnt.src_pkt_cnt[i] <= cnt.src_pkt_cnt[i] + 1'b1;
                end
            end
            if (rx_free) begin
                cnt.down_cnt <= '0;
            end else if (rx_stall && cnt.down_cnt != '1) begin
                cnt.down_cnt <= cnt.down_cnt + 1'b1;    // saturates
            end
            if (cnt.down_cnt > down_cnt_t'(DOWN_LIMIT)) begin
                cnt.stream_down <= 1'b1;                // held until reset
            end
        end
    end

    // delay pipeline
    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            pipe <= '0;
        end else begin
            pipe[0] <= cnt;
            for (int i = 1; i < NET_STATS_DELAY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign stats = pipe[NET_STATS_DELAY-1];

endmodule

// ==== verilog/network_stack.sv ====
// ----------------------------------------------------------
// network stack core
// address registers, receive slice, transmit merge onto
// the network output and traffic statistics
// ----------------------------------------------------------

`timescale 1ns/1ps

module network_stack import net_stream_pkg::*, net_cfg_pkg::*; #(
    parameter mac_addr_t MAC_ADDRESS     = 48'hE59D_0335_0A00,
    parameter ip_addr_t  DEFAULT_IP      = 32'hD1D4_010B,
    parameter ip_addr_t  IP_SUBNET_MASK  = 32'h00FF_FFFF,
    parameter int        N_SOURCES       = N_TX_SOURCES,
    parameter int        NET_STATS_DELAY = 6,
    parameter int        DOWN_LIMIT      = 2
) (
    input  logic                            nclk,
    input  logic                            nresetn_r,

    input  logic                            s_set_ip_addr_valid,
    input  ip_addr_t                        s_set_ip_addr_data,
    input  logic                            s_set_board_valid,
    input  board_num_t                      s_set_board_data,

    input  logic                            s_axis_net_valid,
    output logic                            s_axis_net_ready,
    input  net_beat_t                       s_axis_net_beat,
    output logic                            m_axis_rx_valid,
    input  logic                            m_axis_rx_ready,
    output net_beat_t                       m_axis_rx_beat,

    input  logic      [N_SOURCES-1:0]       s_axis_tx_valid,
    output logic      [N_SOURCES-1:0]       s_axis_tx_ready,
    input  net_beat_t [N_SOURCES-1:0]       s_axis_tx_beat,
    output logic                            m_axis_net_valid,
    input  logic                            m_axis_net_ready,
    output net_beat_t                       m_axis_net_beat,

    output addr_cfg_t                       m_addr_cfg,
    output net_stats_t                      m_net_stats
);

    logic                 arb_valid;        // merge to output slice
    logic                 arb_ready;
    net_beat_t            arb_beat;
    logic [N_SOURCES-1:0] src_last;

    for (genvar i = 0; i < N_SOURCES; i++) begin : g_src_last
        assign src_last[i] = s_axis_tx_beat[i].last;
    end

    // ------------------------------------------------------
    // local addresses
    // ------------------------------------------------------
    net_addr_regs #(
        .MAC_ADDRESS    (MAC_ADDRESS),
        .DEFAULT_IP     (DEFAULT_IP),
        .IP_SUBNET_MASK (IP_SUBNET_MASK)
    ) u_addr_regs (
        .nclk            (nclk),
        .nresetn_r       (nresetn_r),
        .set_ip_valid    (s_set_ip_addr_valid),
        .set_ip_data     (s_set_ip_addr_data),
        .set_board_valid (s_set_board_valid),
        .set_board_data  (s_set_board_data),
        .addr_cfg        (m_addr_cfg)
    );

    // ------------------------------------------------------
    // receive and transmit streams
    // ------------------------------------------------------
    net_reg_slice u_rx_slice (
        .nclk      (nclk),
        .nresetn_r (nresetn_r),
        .s_valid   (s_axis_net_valid),
        .s_ready   (s_axis_net_ready),
        .s_beat    (s_axis_net_beat),
        .m_valid   (m_axis_rx_valid),
        .m_ready   (m_axis_rx_ready),
        .m_beat    (m_axis_rx_beat)
    );

    tx_arbiter #(.N_SOURCES(N_SOURCES)) u_tx_arbiter (
        .nclk      (nclk),
        .nresetn_r (nresetn_r),
        .s_valid   (s_axis_tx_valid),
        .s_ready   (s_axis_tx_ready),
        .s_beat    (s_axis_tx_beat),
        .m_valid   (arb_valid),
        .m_ready   (arb_ready),
        .m_beat    (arb_beat)
    );

    net_reg_slice u_tx_slice (
        .nclk      (nclk),
        .nresetn_r (nresetn_r),
        .s_valid   (arb_valid),
        .s_ready   (arb_ready),
        .s_beat    (arb_beat),
        .m_valid   (m_axis_net_valid),
        .m_ready   (m_axis_net_ready),
        .m_beat    (m_axis_net_beat)
    );

    // ------------------------------------------------------
    // statistics
    // ------------------------------------------------------
    net_stats #(
        .N_SOURCES       (N_SOURCES),
        .NET_STATS_DELAY (NET_STATS_DELAY),
        .DOWN_LIMIT      (DOWN_LIMIT)
    ) u_net_stats (
        .nclk      (nclk),
        .nresetn_r (nresetn_r),
        .rx_valid  (s_axis_net_valid),
        .rx_ready  (s_axis_net_ready),
        .rx_last   (s_axis_net_beat.last),
        .tx_valid  (m_axis_net_valid),
        .tx_ready  (m_axis_net_ready),
        .tx_last   (m_axis_net_beat.last),
        .src_valid (s_axis_tx_valid),
        .src_ready (s_axis_tx_ready),
        .src_last  (src_last),
        .stats     (m_net_stats)
    );

endmodule

// ==== bench/tb_clock.sv ====
// ----------------------------------------------------------
// bench clock and reset
// free-running clock, reset held low for a few cycles
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD       = 20ns,
    parameter int      RESET_CYCLES = 3
) (
    output logic nclk,
    output logic nresetn_r
);

    initial begin
        nclk = 1'b0;
        forever #(PERIOD / 2) nclk = ~nclk;
    end

    initial begin
        nresetn_r = 1'b0;
        repeat (RESET_CYCLES) @(posedge nclk);
        #1 nresetn_r = 1'b1;                // released just after an edge
    end

endmodule

// ==== bench/network_stack_props.sv ====
// ----------------------------------------------------------
// network stack properties
// handshake stability, reset values, sticky stream-down flag
// and the arbiter grant held through a packet
// ----------------------------------------------------------

`timescale 1ns/1ps

module network_stack_props import net_stream_pkg::*, net_cfg_pkg::*; #(
    parameter int N_SOURCES = N_TX_SOURCES
) (
    input logic                      nclk,
    input logic                      nresetn_r,
    input logic                      m_axis_rx_valid,
    input logic                      m_axis_rx_ready,
    input net_beat_t                 m_axis_rx_beat,
    input logic                      m_axis_net_valid,
    input logic                      m_axis_net_ready,
    input net_beat_t                 m_axis_net_beat,
    input net_stats_t                m_net_stats,
    input logic      [N_SOURCES-1:0] s_axis_tx_valid,
    input logic      [N_SOURCES-1:0] s_axis_tx_ready,
    input net_beat_t [N_SOURCES-1:0] s_axis_tx_beat
);

    logic    in_pkt;        // a source is inside a packet
    tx_src_t pkt_src;       // owner of that packet

    always_ff @(posedge nclk) begin
        if (!nresetn_r) begin
            in_pkt  <= 1'b0;
            pkt_src <= '0;
        end else begin
            for (int i = 0; i < N_SOURCES; i++) begin
                if (s_axis_tx_valid[i] && s_axis_tx_ready[i]) begin
                    in_pkt  <= !s_axis_tx_beat[i].last;
                    pkt_src <= tx_src_t'(i);
                end
            end
        end
    end

    a_rx_hold: assert property (@(posedge nclk) disable iff (!nresetn_r)
        m_axis_rx_valid && !m_axis_rx_ready |=> m_axis_rx_valid && $stable(m_axis_rx_beat))
        else $error("receive output changed while stalled");

    a_net_hold: assert property (@(posedge nclk) disable iff (!nresetn_r)
        m_axis_net_valid && !m_axis_net_ready |=> m_axis_net_valid && $stable(m_axis_net_beat))
        else $error("network output changed while stalled");

    a_reset_idle: assert property (@(posedge nclk)
        !nresetn_r |=> !m_axis_rx_valid && !m_axis_net_valid)
        else $error("output valid high after a reset edge");

    a_down_sticky: assert property (@(posedge nclk) disable iff (!nresetn_r)
        m_net_stats.stream_down |=> m_net_stats.stream_down)
        else $error("stream-down flag cleared without reset");

    // no other source is offered the output until the packet ends
    a_grant_held: assert property (@(posedge nclk) disable iff (!nresetn_r)
        in_pkt |-> (s_axis_tx_ready & ~(N_SOURCES'(1) << pkt_src)) == '0)
        else $error("transmit grant moved inside a packet");

endmodule

bind network_stack network_stack_props #(.N_SOURCES(N_SOURCES)) u_props (
    .nclk             (nclk),
    .nresetn_r        (nresetn_r),
    .m_axis_rx_valid  (m_axis_rx_valid),
    .m_axis_rx_ready  (m_axis_rx_ready),
    .m_axis_rx_beat   (m_axis_rx_beat),
    .m_axis_net_valid (m_axis_net_valid),
    .m_axis_net_ready (m_axis_net_ready),
    .m_axis_net_beat  (m_axis_net_beat),
    .m_net_stats      (m_net_stats),
    .s_axis_tx_valid  (s_axis_tx_valid),
    .s_axis_tx_ready  (s_axis_tx_ready),
    .s_axis_tx_beat   (s_axis_tx_beat)
);

// ==== bench/tb_network_stack.sv ====
// ----------------------------------------------------------
// network stack testbench
// address, receive, transmit merge, statistics and
// stream-down tests with scoreboards and a cycle limit
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_network_stack import net_stream_pkg::*, net_cfg_pkg::*;;

    localparam mac_addr_t MAC      = 48'hE59D_0335_0A00;
    localparam ip_addr_t  IP0      = 32'hD1D4_010B;
    localparam ip_addr_t  MASK     = 32'h00FF_FFFF;
    localparam int        NS       = N_TX_SOURCES;
    localparam int        DELAY    = 6;
    localparam int        DOWN_LIM = 2;
    localparam int        MAX_CYC  = 4000;

    logic nclk, nresetn_r;
    logic set_ip_valid, set_board_valid;
    ip_addr_t set_ip_data;
    board_num_t set_board_data;
    logic net_in_valid, net_in_ready, rx_valid, rx_ready;
    net_beat_t net_in_beat, rx_beat;
    logic [NS-1:0] tx_valid, tx_ready;
    net_beat_t [NS-1:0] tx_beat;
    logic net_out_valid, net_out_ready;
    net_beat_t net_out_beat;
    addr_cfg_t addr_cfg;
    net_stats_t stats;

    integer seed = 32'hcc4a_8bf1;
    int errors, checks, cycles, tests;
    int rx_ready_mode;                      // 0 random, 1 low, 2 high
    net_beat_t rx_exp[$];
    net_beat_t tx_exp[NS][$];
    int out_src = -1;
    logic [NS-1:0] src_in_pkt, pending[NS];
    stat_cnt_t sb_rx_words, sb_rx_pkts, sb_tx_words, sb_tx_pkts, sb_src_pkts[NS];

    tb_clock #(.PERIOD(20ns), .RESET_CYCLES(3)) u_clock (.nclk(nclk), .nresetn_r(nresetn_r));

    network_stack #(.MAC_ADDRESS(MAC), .DEFAULT_IP(IP0), .IP_SUBNET_MASK(MASK),
                    .N_SOURCES(NS), .NET_STATS_DELAY(DELAY), .DOWN_LIMIT(DOWN_LIM)) u_dut (
        .nclk(nclk), .nresetn_r(nresetn_r),
        .s_set_ip_addr_valid(set_ip_valid), .s_set_ip_addr_data(set_ip_data),
        .s_set_board_valid(set_board_valid), .s_set_board_data(set_board_data),
        .s_axis_net_valid(net_in_valid), .s_axis_net_ready(net_in_ready),
        .s_axis_net_beat(net_in_beat),
        .m_axis_rx_valid(rx_valid), .m_axis_rx_ready(rx_ready), .m_axis_rx_beat(rx_beat),
        .s_axis_tx_valid(tx_valid), .s_axis_tx_ready(tx_ready), .s_axis_tx_beat(tx_beat),
        .m_axis_net_valid(net_out_valid), .m_axis_net_ready(net_out_ready),
        .m_axis_net_beat(net_out_beat),
        .m_addr_cfg(addr_cfg), .m_net_stats(stats)
    );

    task automatic expect_true(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    function automatic net_beat_t random_beat(input bit last);
        net_beat_t b;
        b.data = {$random(seed), $random(seed)};
        b.keep = last ? net_keep_t'(8'hff >> ($unsigned($random(seed)) % 8)) : '1;
        b.last = last;
        return b;
    endfunction

    function automatic mac_addr_t mac_for_board(input board_num_t bn);
        mac_addr_t m;
        m = MAC;
        m[43:40] = 4'((int'(MAC[43:40]) + int'(bn)) % 16);
        return m;
    endfunction

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %-14s finished, %0d errors", name, errors - errs_before);
    endtask

    // ------------------------------------------------------
    // sink readies, never low two cycles running
    // ------------------------------------------------------
    always @(posedge nclk) begin
        #1;
        net_out_ready <= rx_ready_mode == 2 || (!net_out_ready || ($random(seed) % 4 != 0));
        case (rx_ready_mode)
            1: rx_ready <= 1'b0;
            2: rx_ready <= 1'b1;
            default: rx_ready <= !rx_ready || ($random(seed) % 3 != 0);
        endcase
    end

    // ------------------------------------------------------
    // monitors and scoreboards
    // ------------------------------------------------------
    always @(posedge nclk) begin
        cycles++;
        if (cycles >= MAX_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display("sim failed");
            $finish;
        end else if (nresetn_r) begin
            if (net_in_valid && net_in_ready) begin
                sb_rx_words++;
                if (net_in_beat.last) sb_rx_pkts++;
            end
            if (rx_valid && rx_ready) begin
                expect_true(rx_exp.size() > 0 && rx_beat == rx_exp[0], "receive beat mismatch");
                if (rx_exp.size() > 0) void'(rx_exp.pop_front());
            end
            for (int i = 0; i < NS; i++) begin
                if (tx_valid[i] && tx_ready[i]) begin
                    if (!src_in_pkt[i]) begin
                        expect_true(pending[i] == '0, "waiting source skipped by the merge");
                        for (int t = 0; t < NS; t++) pending[t][i] = 1'b0;
                        pending[i] = tx_valid & ~(NS'(1) << i);
                    end
                    src_in_pkt[i] = !tx_beat[i].last;
                    if (tx_beat[i].last) sb_src_pkts[i]++;
                end
            end
            if (net_out_valid && net_out_ready) begin
                sb_tx_words++;
                if (out_src < 0) begin
                    for (int i = 0; i < NS; i++) begin
                        if (out_src < 0 && tx_exp[i].size() > 0 && tx_exp[i][0] == net_out_beat)
                            out_src = i;
                    end
                end
                expect_true(out_src >= 0, "network output beat matches no source");
                if (out_src >= 0) begin
                    expect_true(tx_exp[out_src][0] == net_out_beat, "transmit packet not contiguous");
                    void'(tx_exp[out_src].pop_front());
                end
                if (net_out_beat.last) begin
                    sb_tx_pkts++;
                    out_src = -1;
                end
            end
        end
    end

    task automatic send_rx_packet(input int len);
        for (int i = 0; i < len; i++) begin
            net_in_beat  = random_beat(i == len - 1);
            net_in_valid = 1'b1;
            rx_exp.push_back(net_in_beat);
            do @(posedge nclk); while (!net_in_ready);
            #1;
        end
        net_in_valid = 1'b0;
    endtask

    // all sources stepped in one process, one beat each per cycle
    task automatic run_tx_sources(input int pkts);
        int sent[NS], idx[NS], len[NS];
        bit busy;
        logic [NS-1:0] accepted;            // handshakes at the last edge
        for (int i = 0; i < NS; i++) begin
            sent[i] = 0;
            idx[i]  = 0;
        end
        accepted = '0;
        do begin
            busy = 0;
            for (int i = 0; i < NS; i++) begin
                if (!tx_valid[i] || accepted[i]) begin
                    tx_valid[i] = 1'b0;
                    if (sent[i] < pkts) begin
                        if (idx[i] == 0) len[i] = 1 + $unsigned($random(seed)) % 6;
                        tx_beat[i]  = random_beat(idx[i] == len[i] - 1);
                        tx_valid[i] = 1'b1;
                        tx_exp[i].push_back(tx_beat[i]);
                        idx[i] = tx_beat[i].last ? 0 : idx[i] + 1;
                        if (tx_beat[i].last) sent[i]++;
                    end
                end
                busy |= tx_valid[i];
            end
            @(posedge nclk);
            accepted = tx_valid & tx_ready;
            #1;
        end while (busy);
    endtask

    initial begin
        int e;
        bit seen;
        int stalls;
        ip_addr_t exp_ip;
        board_num_t boards[2] = '{4'h3, 4'hB};
        set_ip_valid = 0;
        set_ip_data = '0;
        set_board_valid = 0;
        set_board_data = '0;
        net_in_valid = 0;
        net_in_beat = '0;
        tx_valid = '0;
        tx_beat = '0;
        rx_ready = 0;
        net_out_ready = 0;
        rx_ready_mode = 0;
        src_in_pkt = '0;
        sb_rx_words = '0;
        sb_rx_pkts = '0;
        sb_tx_words = '0;
        sb_tx_pkts = '0;
        for (int i = 0; i < NS; i++) begin
            pending[i] = '0;
            sb_src_pkts[i] = '0;
        end
        wait (nresetn_r);
        @(posedge nclk);
        #1;

        e = errors;
        expect_true(!rx_valid && !net_out_valid, "output valid high after reset");
        expect_true(stats == '0, "statistics not zero after reset");
        repeat (2) @(posedge nclk);
        #1;
        expect_true(addr_cfg.ip == IP0 && addr_cfg.subnet_mask == MASK, "reset IP or mask");
        expect_true(addr_cfg.mac == mac_for_board(0), "reset MAC address");
        expect_true(addr_cfg.gateway == {8'h01, IP0[23:0]}, "reset gateway");
        end_test("reset_state", e);

        e = errors;
        foreach (boards[k]) begin
            set_ip_data = $random(seed);
            set_ip_valid = 1;
            set_board_data = boards[k];
            set_board_valid = 1;
            @(posedge nclk);
            #1;
            set_ip_valid = 0;
            set_board_valid = 0;
            repeat (2) @(posedge nclk);
            #1;
            exp_ip = {<<8{set_ip_data}};
            expect_true(addr_cfg.ip == exp_ip, "IP not byte reversed");
            expect_true(addr_cfg.mac == mac_for_board(boards[k]), "MAC board nibble");
            expect_true(addr_cfg.gateway == {8'h01, exp_ip[23:0]}, "gateway rule");
        end
        end_test("address_set", e);

        e = errors;
        for (int p = 0; p < 20; p++) send_rx_packet(1 + $unsigned($random(seed)) % 8);
        wait (rx_exp.size() == 0);
        end_test("receive_path", e);

        e = errors;
        run_tx_sources(6);
        wait (tx_exp[0].size() + tx_exp[1].size() + tx_exp[2].size() + tx_exp[3].size() == 0);
        end_test("transmit_merge", e);

        e = errors;
        repeat (DELAY + 3) @(posedge nclk);
        #1;
        expect_true(stats.rx_word_cnt == sb_rx_words && stats.rx_pkt_cnt == sb_rx_pkts,
                    "receive counters");
        expect_true(stats.tx_word_cnt == sb_tx_words && stats.tx_pkt_cnt == sb_tx_pkts,
                    "transmit counters");
        for (int i = 0; i < NS; i++)
            expect_true(stats.src_pkt_cnt[i] == sb_src_pkts[i], "per-source packet count");
        expect_true(!stats.stream_down, "stream-down flag set by normal traffic");
        end_test("statistics", e);

        e = errors;
        rx_ready_mode = 1;
        seen = 0;
        stalls = 0;
        fork
            send_rx_packet(12);
            begin
                for (int c = 0; c < 40 && !seen; c++) begin
                    @(posedge nclk);
                    if (net_in_valid && !net_in_ready) stalls++;
                    seen = stats.stream_down;
                end
                expect_true(seen, "stream-down flag never rose");
                // limit plus one stalls, then counter, flag, delay and sampling edges
                expect_true(stalls >= DOWN_LIM + DELAY + 4, "stream-down flag rose too early");
                #1 rx_ready_mode = 2;
            end
        join
        wait (rx_exp.size() == 0);
        repeat (DELAY + 4) @(posedge nclk);
        #1;
        expect_true(stats.stream_down, "stream-down flag cleared after ready returned");
        expect_true(stats.down_cnt == '0, "stall count not cleared after ready returned");
        end_test("stream_down", e);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/net_stream_pkg.sv
common/net_cfg_pkg.sv
verilog/net_reg_slice.sv
verilog/net_addr_regs.sv
tx_merge/tx_arbiter.sv
net_stats/net_stats.sv
verilog/network_stack.sv
bench/tb_clock.sv
bench/network_stack_props.sv
bench/tb_network_stack.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the network stack testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_network_stack \
    -f build.f \
    -o sim_network_stack

./obj_dir/sim_network_stack > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    exit 1
fi
